// ==== accel_wrapper.f ====
hw/accel_cfg_pkg.sv
hw/axi_pkg.sv
hw/core_mem_if.sv
hw/apb_cfg_regs.sv
hw/core_reset_seq.sv
hw/copy_core.sv
hw/axi_master_port.sv
hw/accel_wrapper.sv
tests/accel_checker.sv
tests/tb_accel_wrapper.sv

// ==== tests/tb_accel_wrapper.sv ====
// Testbench top with clock, reset, APB driver, AXI memory model with random delays, DUT and checker
`timescale 1ns/100ps

module tb_accel_wrapper;

   localparam int RESET_DELAY = 12;
   localparam int COPY_WORDS  = 8;
   localparam int WAIT_LIMIT  = 2000; // Cycles allowed per wait

   logic        clk;
   logic        reset_pe;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [31:0] paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        awvalid;
   logic        awready;
   logic [31:0] awaddr;
   logic        wvalid;
   logic        wready;
   logic [31:0] wdata;
   logic        bvalid;
   logic        bready;
   logic [1:0]  bresp;
   logic        arvalid;
   logic        arready;
   logic [31:0] araddr;
   logic        rvalid;
   logic        rready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        busy;
   int          mismatch_count;
   int          other_count;
   int          timeouts;
   integer      seed;
   logic [31:0] run_base;
   logic [31:0] err_addr;  // Read address answered with SLVERR
   logic        err_en;
   // Memory model state
   logic        in_reset;  // reset_pe as seen at the edge
   logic        aw_got;
   logic        w_got;
   logic        b_fire;
   logic        r_pend;
   logic        r_fire;
   logic [31:0] r_addr;
   int          b_wait;
   int          r_wait;

   accel_wrapper #(.RESET_DELAY(RESET_DELAY), .COPY_WORDS(COPY_WORDS)) uut (.*);

   accel_checker #(.RESET_DELAY(RESET_DELAY), .COPY_WORDS(COPY_WORDS)) chk (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // AXI memory slave with random ready and response gaps
   ////////////////////////////////////////////////////////////
   always begin
      @(posedge clk);
      in_reset = reset_pe;
      b_fire   = bvalid && bready;
      r_fire   = rvalid && rready;
      if (!in_reset) begin
         if (awvalid && awready) aw_got = 1'b1;
         if (wvalid && wready) w_got = 1'b1;
         if (arvalid && arready) begin
            r_pend = 1'b1;
            r_addr = araddr;
         end
      end
      #1;
      if (in_reset) begin
         aw_got  = 1'b0;
         w_got   = 1'b0;
         r_pend  = 1'b0;
         b_wait  = 0;
         r_wait  = 0;
         bvalid  = 1'b0;
         rvalid  = 1'b0;
         awready = 1'b0;
         wready  = 1'b0;
         arready = 1'b0;
      end else begin
         if (b_fire) bvalid = 1'b0;
         if (r_fire) begin
            rvalid = 1'b0;
            r_pend = 1'b0;
         end
         if (aw_got && w_got && !bvalid) begin // Both halves of the write are in
            if (b_wait == 0) begin
               bvalid = 1'b1;
               bresp  = axi_pkg::OKAY;
               aw_got = 1'b0;
               w_got  = 1'b0;
               b_wait = $random(seed) & 3;
            end else begin
               b_wait--;
            end
         end
         if (r_pend && !rvalid) begin
            if (r_wait == 0) begin
               rvalid = 1'b1;
               rdata  = $random(seed);
               rresp  = (err_en && r_addr == err_addr) ? axi_pkg::SLVERR : axi_pkg::OKAY;
               r_wait = $random(seed) & 3;
            end else begin
               r_wait--;
            end
         end
         awready = !aw_got && (($random(seed) & 3) != 0);
         wready  = !w_got && (($random(seed) & 3) != 0);
         arready = !r_pend && (($random(seed) & 3) != 0);
      end
   end

   // Access phase after the setup phase already on the bus
   task automatic access_phase;
      int n;
      n = 0;
      @(posedge clk);
      #1 penable = 1'b1;
      @(posedge clk);
      while (pready !== 1'b1 && n < WAIT_LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (pready !== 1'b1) begin
         $display("Timeout: APB access to 0x%08h never got pready", paddr);
         timeouts++;
      end
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
      if (timeouts == 0) begin
         psel   = 1'b1;
         pwrite = 1'b1;
         paddr  = addr;
         pwdata = data;
         access_phase();
      end
   endtask

   task automatic read_reg(input logic [31:0] addr);
      if (timeouts == 0) begin
         psel   = 1'b1;
         pwrite = 1'b0;
         paddr  = addr;
         access_phase();
      end
   endtask

   task automatic wait_busy(input logic level);
      int n;
      n = 0;
      if (timeouts == 0) begin
         @(posedge clk);
         while (busy !== level && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
         end
         if (busy !== level) begin
            $display("Timeout: busy did not reach %0b within %0d cycles", level, WAIT_LIMIT);
            timeouts++;
         end
         #1;
      end
   endtask

   // Restart the core and let one block copy finish
   task automatic run_copy;
      write_reg(accel_cfg_pkg::REG_START, 32'h0);
      write_reg(accel_cfg_pkg::REG_START, 32'h1);
      wait_busy(1'b1);
      read_reg(accel_cfg_pkg::REG_STATUS); // Mid-run
      wait_busy(1'b0);
      read_reg(accel_cfg_pkg::REG_STATUS);
   endtask

   initial begin
      seed     = 32'hf027_a368;
      timeouts = 0;
      err_en   = 1'b0;
      err_addr = '0;
      reset_pe = 1'b1;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      paddr    = '0;
      pwdata   = '0;
      awready  = 1'b0;
      wready   = 1'b0;
      bvalid   = 1'b0;
      bresp    = '0;
      arready  = 1'b0;
      rvalid   = 1'b0;
      rdata    = '0;
      rresp    = '0;
      repeat (4) @(posedge clk);
      #1 reset_pe = 1'b0;

      write_reg(accel_cfg_pkg::REG_BASE, 32'h1000_0000);
      read_reg(accel_cfg_pkg::REG_BASE);
      read_reg(32'h0000_005c); // Unmapped
      read_reg(accel_cfg_pkg::REG_STATUS);
      run_copy();

      run_base = $random(seed) & 32'hffff_ff00;
      write_reg(accel_cfg_pkg::REG_BASE, run_base);
      read_reg(accel_cfg_pkg::REG_BASE);
      run_copy();

      // Word 3 of the last run gets a slave error
      err_addr = run_base + 32'h0000_000c;
      err_en   = 1'b1;
      run_copy();
      write_reg(accel_cfg_pkg::REG_START, 32'h0); // Clears the error bit
      read_reg(accel_cfg_pkg::REG_STATUS);

      $display("Run finished: %0d mismatches, %0d other errors, %0d timeouts",
               mismatch_count, other_count, timeouts);
      if (mismatch_count == 0 && other_count == 0 && timeouts == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== tests/accel_checker.sv ====
// Checker: APB and AXI monitor with copy model, busy timing, register read-back and error counts
`timescale 1ns/100ps

module accel_checker #(
   parameter int RESET_DELAY = 12,
   parameter int COPY_WORDS  = 8
) (
   input  logic        clk,
   input  logic        reset_pe,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [31:0] paddr,
   input  logic [31:0] pwdata,
   input  logic [31:0] prdata,
   input  logic        awvalid,
   input  logic        awready,
   input  logic [31:0] awaddr,
   input  logic        wvalid,
   input  logic        wready,
   input  logic [31:0] wdata,
   input  logic        bvalid,
   input  logic        bready,
   input  logic [1:0]  bresp,
   input  logic        arvalid,
   input  logic        arready,
   input  logic [31:0] araddr,
   input  logic        rvalid,
   input  logic        rready,
   input  logic [31:0] rdata,
   input  logic [1:0]  rresp,
   input  logic        busy,
   output int          mismatch_count,
   output int          other_count
);

   logic [31:0] base_m;      // Modelled base register
   logic        start_m;
   logic        err_m;       // Modelled sticky error
   logic        started;     // Start bit rose, run not stopped
   logic        done;        // Last write response seen
   int          since;       // Edges since the start write
   int          rd_idx;
   int          aw_idx;
   int          b_idx;
   logic [31:0] rd_q[$];     // Read data waiting for its write
   logic [31:0] exp_prdata;  // Loaded in the APB setup phase
   logic        exp_busy;
   logic        wr_start;
   logic        err_set;

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
         mismatch_count++;
      end
   endtask

   task automatic note_fault(input string what);
      $display("%s at %0t", what, $time);
      other_count++;
   endtask

   initial begin
      mismatch_count = 0;
      other_count    = 0;
   end

   always @(posedge clk) begin
      if (reset_pe) begin
         base_m  = '0;
         start_m = 1'b0;
         err_m   = 1'b0;
         started = 1'b0;
         done    = 1'b0;
         since   = 0;
      end else begin
         wr_start = psel && penable && pwrite && paddr[7:0] == accel_cfg_pkg::REG_START;
         err_set  = 1'b0;

         ////////////////////////////////////////////////////////////
         // Run timing and busy
         ////////////////////////////////////////////////////////////
         if (started) since++;
         if (wr_start && pwdata[0] && !start_m) begin // Rising start, new run
            started = 1'b1;
            done    = 1'b0;
            since   = 0;
            rd_idx  = 0;
            aw_idx  = 0;
            b_idx   = 0;
            rd_q.delete();
         end else if (wr_start && !pwdata[0]) begin
            started = 1'b0;
         end
         // Core reset for RESET_DELAY cycles, then run enable, seen one edge later
         exp_busy = started && !done && since >= RESET_DELAY + 3;
         compare_value("busy", busy, exp_busy);

         // APB read-back
         if (psel && penable && !pwrite) compare_value("prdata", prdata, exp_prdata);
         if (psel && !penable && !pwrite) begin
            case (paddr[7:0])
               accel_cfg_pkg::REG_BASE:   exp_prdata = base_m;
               accel_cfg_pkg::REG_START:  exp_prdata = {31'b0, start_m};
               accel_cfg_pkg::REG_STATUS: exp_prdata = {30'b0, err_m, exp_busy};
               default:                   exp_prdata = '0;
            endcase
         end

         ////////////////////////////////////////////////////////////
         // AXI traffic against the copy model
         ////////////////////////////////////////////////////////////
         if ((arvalid || awvalid) && (!started || done || since < RESET_DELAY))
            note_fault("AXI request issued outside a running copy");
         if (arvalid && arready) begin
            compare_value("araddr", araddr, base_m + 32'(4 * rd_idx));
            rd_idx++;
         end
         if (rvalid && rready) begin
            rd_q.push_back(rdata);
            if (rresp != axi_pkg::OKAY) err_set = 1'b1;
         end
         if (awvalid && awready) begin
            compare_value("awaddr", awaddr,
                          base_m + accel_cfg_pkg::DST_OFFSET + 32'(4 * aw_idx));
            aw_idx++;
         end
         if (wvalid && wready) begin
            if (rd_q.size() == 0) note_fault("Write data sent before its read returned");
            else compare_value("wdata", wdata, rd_q.pop_front() + 32'd1);
         end
         if (bvalid && bready) begin
            if (bresp != axi_pkg::OKAY) err_set = 1'b1;
            b_idx++;
            if (b_idx == COPY_WORDS) done = 1'b1;
         end

         // Register model, error set wins over the clear
         if (psel && penable && pwrite && paddr[7:0] == accel_cfg_pkg::REG_BASE) base_m = pwdata;
         if (wr_start) begin
            start_m = pwdata[0];
            err_m   = 1'b0;
         end
         if (err_set) err_m = 1'b1;
      end
   end

endmodule

// ==== hw/accel_wrapper.sv ====
// Accelerator wrapper top: APB registers, core reset sequencer, copy core and AXI master port
`timescale 1ns/100ps

module accel_wrapper #(
   parameter int RESET_DELAY = 12,
   parameter int COPY_WORDS  = 8
) (
   input  logic                              clk,
   input  logic                              reset_pe,
   // APB configuration
   input  logic                              psel,
   input  logic                              penable,
   input  logic                              pwrite,
   input  logic [accel_cfg_pkg::ADDR_W-1:0] paddr,
   input  logic [accel_cfg_pkg::DATA_W-1:0] pwdata,
   output logic [accel_cfg_pkg::DATA_W-1:0] prdata,
   output logic                              pready,
   // AXI master
   output logic                              awvalid,
   input  logic                              awready,
   output logic [accel_cfg_pkg::ADDR_W-1:0] awaddr,
   output logic                              wvalid,
   input  logic                              wready,
   output logic [accel_cfg_pkg::DATA_W-1:0] wdata,
   input  logic                              bvalid,
   output logic                              bready,
   input  logic [1:0]                        bresp,
   output logic                              arvalid,
   input  logic                              arready,
   output logic [accel_cfg_pkg::ADDR_W-1:0] araddr,
   input  logic                              rvalid,
   output logic                              rready,
   input  logic [accel_cfg_pkg::DATA_W-1:0] rdata,
   input  logic [1:0]                        rresp,
   // Status
   output logic                              busy
);

   logic [accel_cfg_pkg::ADDR_W-1:0] base;
   logic                              start;
   logic                              core_rst;
   logic                              core_run;

   core_mem_if mem_if ();

   assign pready = 1'b1; // No wait states

   apb_cfg_regs u_regs (
      .clk(clk), .reset_pe(reset_pe),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
      .prdata(prdata), .base(base), .start(start), .busy(busy), .err(mem_if.err)
   );

   core_reset_seq #(.RESET_DELAY(RESET_DELAY)) u_seq (
      .clk(clk), .reset_pe(reset_pe), .start(start),
      .core_rst(core_rst), .core_run(core_run)
   );

   copy_core #(.COPY_WORDS(COPY_WORDS)) u_core (
      .clk(clk), .core_rst(core_rst), .core_run(core_run), .busy(busy), .mem(mem_if.core)
   );

   axi_master_port u_port (
      .clk(clk), .reset_pe(reset_pe), .base(base), .mem(mem_if.port),
      .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
      .wvalid(wvalid), .wready(wready), .wdata(wdata),
      .bvalid(bvalid), .bready(bready), .bresp(bresp),
      .arvalid(arvalid), .arready(arready), .araddr(araddr),
      .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
   );

endmodule

// ==== hw/axi_master_port.sv ====
// AXI master port: address rebasing, registered AXI channels, acks and errors back to the core
`timescale 1ns/100ps

module axi_master_port (
   input  logic                              clk,
   input  logic                              reset_pe,
   input  logic [accel_cfg_pkg::ADDR_W-1:0] base,
   core_mem_if.port                          mem,
   // Write address
   output logic                              awvalid,
   input  logic                              awready,
   output logic [accel_cfg_pkg::ADDR_W-1:0] awaddr,
   // Write data
   output logic                              wvalid,
   input  logic                              wready,
   output logic [accel_cfg_pkg::DATA_W-1:0] wdata,
   // Write response
   input  logic                              bvalid,
   output logic                              bready,
   input  logic [1:0]                        bresp,
   // Read address
   output logic                              arvalid,
   input  logic                              arready,
   output logic [accel_cfg_pkg::ADDR_W-1:0] araddr,
   // Read data
   input  logic                              rvalid,
   output logic                              rready,
   input  logic [accel_cfg_pkg::DATA_W-1:0] rdata,
   input  logic [1:0]                        rresp
);

   axi_pkg::chan_state_e wr_state;
   logic                 rd_pend;  // Read issued, R not yet seen
   logic                 aw_left;
   logic                 w_left;

   assign aw_left = awvalid & ~awready;
   assign w_left  = wvalid & ~wready;

   ////////////////////////////////////////////////////////////
   // Write channel
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset_pe) begin
         wr_state <= axi_pkg::C_IDLE;
         awvalid  <= 1'b0;
         wvalid   <= 1'b0;
      end else begin
         case (wr_state)
            axi_pkg::C_IDLE: begin
               if (mem.wr_req) begin // AW and W go out together
                  awvalid  <= 1'b1;
                  wvalid   <= 1'b1;
                  wr_state <= axi_pkg::C_ADDR;
               end
            end
            axi_pkg::C_ADDR: begin
               awvalid <= aw_left;
               wvalid  <= w_left;
               if (!aw_left) wr_state <= w_left ? axi_pkg::C_DATA : axi_pkg::C_RESP;
            end
            axi_pkg::C_DATA: begin
               if (wready) begin
                  wvalid   <= 1'b0;
                  wr_state <= axi_pkg::C_RESP;
               end
            end
            axi_pkg::C_RESP: if (bvalid) wr_state <= axi_pkg::C_IDLE;
            default: wr_state <= axi_pkg::C_IDLE;
         endcase
      end
   end

   // Read channel, one read in flight
   always_ff @(posedge clk) begin
      if (reset_pe) begin
         rd_pend <= 1'b0;
         arvalid <= 1'b0;
      end else if (!rd_pend) begin
         if (mem.rd_req) begin
            rd_pend <= 1'b1;
            arvalid <= 1'b1;
         end
      end else begin
         if (arready) arvalid <= 1'b0;
         if (rvalid && rready) rd_pend <= 1'b0;
      end
   end

   // Rebased addresses and write data, loaded at issue
   always_ff @(posedge clk) begin
      if (wr_state == axi_pkg::C_IDLE && mem.wr_req) begin
         awaddr <= mem.wr_addr + base;
         wdata  <= mem.wr_data;
      end
      if (!rd_pend && mem.rd_req) araddr <= mem.rd_addr + base;
   end

   assign bready = (wr_state == axi_pkg::C_RESP);
   assign rready = rd_pend & ~arvalid;

   ////////////////////////////////////////////////////////////
   // Responses back to the core
   ////////////////////////////////////////////////////////////
   assign mem.rd_ack  = rready & rvalid;
   assign mem.rd_data = rdata;
   assign mem.wr_ack  = bready & bvalid;
   assign mem.err     = (mem.rd_ack & (axi_pkg::resp_e'(rresp) != axi_pkg::OKAY)) |
                        (mem.wr_ack & (axi_pkg::resp_e'(bresp) != axi_pkg::OKAY));

   // Payload must hold while the slave stalls
   a_awaddr_stable: assert property (@(posedge clk) disable iff (reset_pe)
      aw_left |=> $stable(awaddr));
   a_wdata_stable: assert property (@(posedge clk) disable iff (reset_pe)
      w_left |=> $stable(wdata));
   a_araddr_stable: assert property (@(posedge clk) disable iff (reset_pe)
      (arvalid && !arready) |=> $stable(araddr));

endmodule

// ==== hw/copy_core.sv ====
// Copy core: reads a block of words, adds one to each and writes them to the destination block
`timescale 1ns/100ps

module copy_core #(
   parameter int COPY_WORDS = 8
) (
   input  logic     clk,
   input  logic     core_rst,
   input  logic     core_run,
   output logic     busy,
   core_mem_if.core mem
);

   localparam int IDX_W = $clog2(COPY_WORDS + 1);
   localparam int AW    = accel_cfg_pkg::ADDR_W;

   accel_cfg_pkg::core_state_e       state;
   logic [IDX_W-1:0]                 idx;       // Current word
   logic [AW-1:0]                    word_off;  // Byte offset of current word
   logic [accel_cfg_pkg::DATA_W-1:0] wr_data_q;

   assign word_off = AW'(idx) * AW'(axi_pkg::BEAT_BYTES);

   ////////////////////////////////////////////////////////////
   // Request side of the memory interface
   ////////////////////////////////////////////////////////////
   // Requests only while running, state is unknown before the first core reset
   assign mem.rd_req  = core_run & ((state == accel_cfg_pkg::RD_REQ) ||
                                    (state == accel_cfg_pkg::RD_WAIT));
   assign mem.wr_req  = core_run & ((state == accel_cfg_pkg::WR_REQ) ||
                                    (state == accel_cfg_pkg::WR_WAIT));
   assign mem.rd_addr = word_off;
   assign mem.wr_addr = accel_cfg_pkg::DST_OFFSET + word_off;
   assign mem.wr_data = wr_data_q;

   // High from the first run cycle until the block is done
   assign busy = core_run & (state != accel_cfg_pkg::DONE);

   always_ff @(posedge clk) begin
      if (core_rst) begin
         state <= accel_cfg_pkg::IDLE;
         idx   <= '0;
      end else if (core_run) begin
         case (state)
            accel_cfg_pkg::IDLE: begin
               state <= accel_cfg_pkg::RD_REQ;
               idx   <= '0;
            end
            accel_cfg_pkg::RD_REQ:  state <= accel_cfg_pkg::RD_WAIT;
            accel_cfg_pkg::RD_WAIT: begin
               if (mem.rd_ack) state <= accel_cfg_pkg::WR_REQ;
            end
            accel_cfg_pkg::WR_REQ:  state <= accel_cfg_pkg::WR_WAIT;
            accel_cfg_pkg::WR_WAIT: begin
               if (mem.wr_ack) begin
                  if (idx == IDX_W'(COPY_WORDS - 1)) begin
                     state <= accel_cfg_pkg::DONE;
                  end else begin
                     idx   <= idx + 1'b1;
                     state <= accel_cfg_pkg::RD_REQ;
                  end
               end
            end
            accel_cfg_pkg::DONE: ; // Stay until core_rst
            default: state <= accel_cfg_pkg::IDLE;
         endcase
      end
   end

   // Word to write back
   always_ff @(posedge clk) begin
      if (mem.rd_ack && state == accel_cfg_pkg::RD_WAIT) begin
         wr_data_q <= mem.rd_data + 1'b1;
      end
   end

endmodule

// ==== hw/core_reset_seq.sv ====
// Core reset sequencer: multicycle core reset and run enable after the start bit rises
`timescale 1ns/100ps

module core_reset_seq #(
   parameter int RESET_DELAY = 12
) (
   input  logic clk,
   input  logic reset_pe,
   input  logic start,
   output logic core_rst,
   output logic core_run
);

   localparam int CNT_W = $clog2(RESET_DELAY + 1);

   accel_cfg_pkg::seq_state_e state;
   logic                      start_q;  // For rising edge of start
   logic [CNT_W-1:0]          hold_cnt;

   always_ff @(posedge clk) begin
      if (reset_pe) begin
         state    <= accel_cfg_pkg::SEQ_IDLE;
         start_q  <= 1'b0;
         core_rst <= 1'b0;
         core_run <= 1'b0;
         hold_cnt <= '0;
      end else begin
         start_q <= start;
         case (state)
            accel_cfg_pkg::SEQ_IDLE: begin
               if (start && !start_q) begin
                  state    <= accel_cfg_pkg::SEQ_HOLD;
                  core_rst <= 1'b1;
                  hold_cnt <= '0;
               end
            end
            accel_cfg_pkg::SEQ_HOLD: begin
               if (!start) begin            // Software abort
                  state    <= accel_cfg_pkg::SEQ_IDLE;
                  core_rst <= 1'b0;
               end else if (hold_cnt == CNT_W'(RESET_DELAY - 1)) begin
                  state    <= accel_cfg_pkg::SEQ_RUN;
                  core_rst <= 1'b0;
               end else begin
                  hold_cnt <= hold_cnt + 1'b1;
               end
            end
            accel_cfg_pkg::SEQ_RUN: begin
               if (!start) begin
                  state    <= accel_cfg_pkg::SEQ_IDLE;
                  core_run <= 1'b0;
               end else begin
                  core_run <= 1'b1; // One cycle after reset release
               end
            end
            default: state <= accel_cfg_pkg::SEQ_IDLE;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////
   a_rst_len: assert property (@(posedge clk) disable iff (reset_pe || !start)
      $rose(core_rst) |-> core_rst [*RESET_DELAY] ##1 !core_rst);

   a_rst_run_excl: assert property (@(posedge clk) disable iff (reset_pe)
      !(core_rst && core_run));

endmodule

// ==== hw/apb_cfg_regs.sv ====
// APB register block: base offset, start bit, status read-back with sticky error flag
`timescale 1ns/100ps

module apb_cfg_regs (
   input  logic                              clk,
   input  logic                              reset_pe,
   input  logic                              psel,
   input  logic                              penable,
   input  logic                              pwrite,
   input  logic [accel_cfg_pkg::ADDR_W-1:0] paddr,
   input  logic [accel_cfg_pkg::DATA_W-1:0] pwdata,
   output logic [accel_cfg_pkg::DATA_W-1:0] prdata,
   output logic [accel_cfg_pkg::ADDR_W-1:0] base,
   output logic                              start,
   input  logic                              busy,
   input  logic                              err
);

   localparam int DW = accel_cfg_pkg::DATA_W;

   logic                     apb_write;
   logic                     apb_read;
   logic                     err_flag;   // Sticky until REG_START is written
   accel_cfg_pkg::reg_addr_e reg_sel;

   assign apb_write = psel & penable & pwrite; // Access phase only
   assign apb_read  = psel & ~pwrite;          // Setup phase, data ready for access phase
   assign reg_sel   = accel_cfg_pkg::reg_addr_e'(paddr[7:0]);

   ////////////////////////////////////////////////////////////
   // Writable registers
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset_pe) begin
         base     <= '0;
         start    <= 1'b0;
         err_flag <= 1'b0;
      end else begin
         if (apb_write) begin
            case (reg_sel)
               accel_cfg_pkg::REG_BASE:  base <= pwdata;
               accel_cfg_pkg::REG_START: begin
                  start    <= pwdata[0];
                  err_flag <= 1'b0; // New run, fresh error state
               end
               default: ;
            endcase
         end
         if (err) err_flag <= 1'b1; // Set wins over clear
      end
   end

   // Read-back
   always_ff @(posedge clk) begin
      if (reset_pe) begin
         prdata <= '0;
      end else if (apb_read) begin
         case (reg_sel)
            accel_cfg_pkg::REG_BASE:   prdata <= base;
            accel_cfg_pkg::REG_START:  prdata <= {{(DW-1){1'b0}}, start};
            accel_cfg_pkg::REG_STATUS: prdata <= {{(DW-2){1'b0}}, err_flag, busy};
            default:                   prdata <= '0; // Unmapped
         endcase
      end
   end

endmodule

// ==== hw/core_mem_if.sv ====
// Core memory interface: raw read and write requests with acknowledges and error pulse
`timescale 1ns/100ps

interface core_mem_if;

   // Read request and response
   logic                              rd_req;
   logic [accel_cfg_pkg::ADDR_W-1:0] rd_addr;
   logic                              rd_ack;  // One cycle, data valid with it
   logic [accel_cfg_pkg::DATA_W-1:0] rd_data;

   // Write request and response
   logic                              wr_req;
   logic [accel_cfg_pkg::ADDR_W-1:0] wr_addr;
   logic [accel_cfg_pkg::DATA_W-1:0] wr_data;
   logic                              wr_ack;

   logic                              err;     // Pulses with an ack whose response was not OKAY

   // Requester side
   modport core (
      output rd_req, rd_addr, wr_req, wr_addr, wr_data,
      input  rd_ack, rd_data, wr_ack, err
   );

   // Bus port side
   modport port (
      input  rd_req, rd_addr, wr_req, wr_addr, wr_data,
      output rd_ack, rd_data, wr_ack, err
   );

endinterface

// ==== hw/axi_pkg.sv ====
// AXI package: response codes, single beat size constants, write channel states
package axi_pkg;

   // xRESP encoding
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } resp_e;

   ////////////////////////////////////////////////////////////
   // Transfer size, every transfer is one full width beat
   ////////////////////////////////////////////////////////////
   localparam logic [2:0] BEAT_SIZE  = 3'b010;          // AxSIZE code for 4 bytes
   localparam int         BEAT_BYTES = 1 << BEAT_SIZE;  // Address step per word

   // Write channel of the master port
   typedef enum logic [1:0] {
      C_IDLE, // No write outstanding
      C_ADDR, // AW still waiting, W may be waiting too
      C_DATA, // AW accepted, W still waiting
      C_RESP  // Both accepted, waiting for B
   } chan_state_e;

endpackage

// ==== hw/accel_cfg_pkg.sv ====
// Accelerator config package: bus widths, register map, destination offset, FSM state enums
package accel_cfg_pkg;

   localparam int DATA_W = 32; // Data path width
   localparam int ADDR_W = 32; // Address width, APB and AXI

   // Raw start address of the copy destination block
   localparam logic [ADDR_W-1:0] DST_OFFSET = 32'h0000_0100;

   ////////////////////////////////////////////////////////////
   // Register offsets on paddr[7:0]
   ////////////////////////////////////////////////////////////
   typedef enum logic [7:0] {
      REG_BASE   = 8'h50, // Memory base offset
      REG_START  = 8'h54, // Bit 0 starts the core, 0 stops it
      REG_STATUS = 8'h58  // Bit 0 busy, bit 1 sticky memory error
   } reg_addr_e;

   // Reset sequencer
   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_HOLD, // Core held in reset
      SEQ_RUN
   } seq_state_e;

   // Copy core
   typedef enum logic [2:0] {
      IDLE,
      RD_REQ,
      RD_WAIT,
      WR_REQ,
      WR_WAIT,
      DONE // Block copied, wait for the next core reset
   } core_state_e;

endpackage
